//--- design/stq_consts.svh
`ifndef STQ_CONSTS_SVH
`define STQ_CONSTS_SVH

// queue depth
`define STQ_ENTRIES 4

// store address width
`define STQ_ADDR_W 32

// store data width, one strobe bit per byte
`define STQ_DATA_W 32

`endif

//--- design/stq_pkg.sv
package stq_pkg;

`include "stq_consts.svh"

  // index and occupancy widths
  localparam int IDX_W = $clog2(`STQ_ENTRIES);
  localparam int CNT_W = $clog2(`STQ_ENTRIES + 1);

  typedef logic [IDX_W-1:0]           stq_idx_t;
  typedef logic [CNT_W-1:0]           stq_cnt_t;
  typedef logic [`STQ_ENTRIES-1:0]    stq_oh_t;

  typedef logic [`STQ_ADDR_W-1:0]     addr_t;
  typedef logic [`STQ_DATA_W-1:0]     data_t;
  typedef logic [`STQ_DATA_W/8-1:0]   strb_t;

  // access size code
  typedef logic [1:0] st_size_t;

  localparam st_size_t SIZE_BYTE = 2'd0;
  localparam st_size_t SIZE_HALF = 2'd1;
  localparam st_size_t SIZE_WORD = 2'd2;

  // entry lifecycle
  typedef enum logic [2:0] {
    STQ_FREE        = 3'd0,
    STQ_WAIT_EXEC   = 3'd1,
    STQ_WAIT_COMMIT = 3'd2,
    STQ_COMMITTED   = 3'd3,
    STQ_DRAINING    = 3'd4
  } stq_state_e;

endpackage

//--- design/stq_upd_if.sv
`timescale 1ns/1ns

interface stq_upd_if;
  import stq_pkg::*;

  // one-hot commands, one bit per entry
  stq_oh_t  alloc_oh;
  stq_oh_t  exec_oh;
  stq_oh_t  commit_oh;
  stq_oh_t  drain_oh;
  stq_oh_t  free_oh;

  // drops every uncommitted entry
  logic     flush;

  // execute payload shared by all entries
  addr_t    exec_addr;
  data_t    exec_data;
  st_size_t exec_size;

  modport ctrl (
    output alloc_oh, exec_oh, commit_oh, drain_oh, free_oh,
    output flush,
    output exec_addr, exec_data, exec_size
  );

  modport entry (
    input alloc_oh, exec_oh, commit_oh, drain_oh, free_oh,
    input flush,
    input exec_addr, exec_data, exec_size
  );

endinterface

//--- design/stq_entry.sv
`timescale 1ns/1ns

module stq_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  stq_upd_if.entry             upd,

  output stq_pkg::stq_state_e  o_state,
  output stq_pkg::addr_t       o_addr,
  output stq_pkg::data_t       o_data,
  output stq_pkg::st_size_t    o_size
);
  import stq_pkg::*;

  stq_state_e r_state;
  addr_t      r_addr;
  data_t      r_data;
  st_size_t   r_size;

  logic w_alloc;
  logic w_exec;
  logic w_commit;
  logic w_drain;
  logic w_free;

  // this entry's slice of each command
  assign w_alloc  = upd.alloc_oh[ENTRY_IDX];
  assign w_exec   = upd.exec_oh[ENTRY_IDX];
  assign w_commit = upd.commit_oh[ENTRY_IDX];
  assign w_drain  = upd.drain_oh[ENTRY_IDX];
  assign w_free   = upd.free_oh[ENTRY_IDX];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= STQ_FREE;
    end else begin
      case (r_state)
        STQ_FREE: begin
          if (w_alloc) begin
            r_state <= STQ_WAIT_EXEC;
          end
        end
        STQ_WAIT_EXEC: begin
          if (upd.flush) begin
            r_state <= STQ_FREE;
          end else if (w_exec) begin
            r_state <= STQ_WAIT_COMMIT;
          end
        end
        STQ_WAIT_COMMIT: begin
          if (upd.flush) begin
            r_state <= STQ_FREE;
          end else if (w_commit) begin
            r_state <= STQ_COMMITTED;
          end
        end
        // past commit a flush no longer applies
        STQ_COMMITTED: begin
          if (w_drain) begin
            r_state <= STQ_DRAINING;
          end
        end
        STQ_DRAINING: begin
          if (w_free) begin
            r_state <= STQ_FREE;
          end
        end
        default: begin
          r_state <= STQ_FREE;
        end
      endcase
    end
  end

  // payload is taken on the way into WAIT_COMMIT
  always_ff @(posedge i_clk) begin
    if (w_exec && r_state == STQ_WAIT_EXEC && !upd.flush) begin
      r_addr <= upd.exec_addr;
      r_data <= upd.exec_data;
      r_size <= upd.exec_size;
    end
  end

  assign o_state = r_state;
  assign o_addr  = r_addr;
  assign o_data  = r_data;
  assign o_size  = r_size;

endmodule

//--- design/stq_ctrl.sv
`timescale 1ns/1ns
`include "stq_consts.svh"

module stq_ctrl (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic                 i_disp_valid,
  output logic                 o_disp_ready,
  output stq_pkg::stq_idx_t    o_disp_idx,

  input  logic                 i_ex_valid,
  input  stq_pkg::stq_idx_t    i_ex_idx,
  input  stq_pkg::addr_t       i_ex_addr,
  input  stq_pkg::data_t       i_ex_data,
  input  stq_pkg::st_size_t    i_ex_size,

  input  logic                 i_commit_valid,
  input  logic                 i_flush,

  input  stq_pkg::stq_state_e  i_entry_state [`STQ_ENTRIES],
  input  logic                 i_drain_busy,
  input  logic                 i_drain_accept,
  output stq_pkg::stq_idx_t    o_head_idx,
  output logic                 o_drain_load,

  stq_upd_if.ctrl              upd
);
  import stq_pkg::*;

  // tail allocates, cmt commits next, head drains next
  stq_idx_t r_tail;
  stq_idx_t r_cmt;
  stq_idx_t r_head;
  stq_cnt_t r_count;

  stq_cnt_t w_kept;
  logic     w_disp;

  function automatic stq_idx_t inc_idx(input stq_idx_t idx);
    if (idx == stq_idx_t'(`STQ_ENTRIES - 1)) begin
      return '0;
    end
    return idx + stq_idx_t'(1);
  endfunction

  assign o_disp_ready = (r_count != stq_cnt_t'(`STQ_ENTRIES));
  assign o_disp_idx   = r_tail;
  assign w_disp       = i_disp_valid & o_disp_ready;

  // head is committed and nothing sits in the output register
  assign o_drain_load = (i_entry_state[r_head] == STQ_COMMITTED) & !i_drain_busy;
  assign o_head_idx   = r_head;

  assign upd.alloc_oh  = w_disp ? (stq_oh_t'(1) << r_tail) : '0;
  assign upd.exec_oh   = i_ex_valid ? (stq_oh_t'(1) << i_ex_idx) : '0;
  assign upd.commit_oh = i_commit_valid ? (stq_oh_t'(1) << r_cmt) : '0;
  assign upd.drain_oh  = o_drain_load ? (stq_oh_t'(1) << r_head) : '0;
  assign upd.free_oh   = i_drain_accept ? (stq_oh_t'(1) << r_head) : '0;
  assign upd.flush     = i_flush;
  assign upd.exec_addr = i_ex_addr;
  assign upd.exec_data = i_ex_data;
  assign upd.exec_size = i_ex_size;

  // entries that survive a flush
  always_comb begin
    w_kept = '0;
    for (int i = 0; i < `STQ_ENTRIES; i++) begin
      if (i_entry_state[i] == STQ_COMMITTED || i_entry_state[i] == STQ_DRAINING) begin
        w_kept = w_kept + stq_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail  <= '0;
      r_cmt   <= '0;
      r_head  <= '0;
      r_count <= '0;
    end else begin
      if (i_flush) begin
        r_tail <= r_cmt;
      end else if (w_disp) begin
        r_tail <= inc_idx(r_tail);
      end

      if (i_commit_valid) begin
        r_cmt <= inc_idx(r_cmt);
      end

      if (i_drain_accept) begin
        r_head <= inc_idx(r_head);
      end

      // a drain may finish in the flush cycle
      if (i_flush) begin
        r_count <= w_kept - stq_cnt_t'(i_drain_accept);
      end else begin
        r_count <= r_count + stq_cnt_t'(w_disp) - stq_cnt_t'(i_drain_accept);
      end
    end
  end

endmodule

//--- design/stq_drain.sv
`timescale 1ns/1ns
`include "stq_consts.svh"

module stq_drain (
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_load,
  input  stq_pkg::addr_t     i_addr,
  input  stq_pkg::data_t     i_data,
  input  stq_pkg::st_size_t  i_size,

  output logic               o_accept,
  output logic               o_busy,

  output logic               o_mem_valid,
  input  logic               i_mem_ready,
  output stq_pkg::addr_t     o_mem_addr,
  output stq_pkg::data_t     o_mem_data,
  output stq_pkg::strb_t     o_mem_strb
);
  import stq_pkg::*;

  logic  r_valid;
  addr_t r_addr;
  data_t r_data;
  strb_t r_strb;

  strb_t w_strb;
  data_t w_data;

  // lanes from size and low address bits
  always_comb begin
    case (i_size)
      SIZE_BYTE: begin
        w_strb = strb_t'(1) << i_addr[1:0];
        w_data = {(`STQ_DATA_W/8){i_data[7:0]}};
      end
      SIZE_HALF: begin
        w_strb = strb_t'(3) << {i_addr[1], 1'b0};
        w_data = {(`STQ_DATA_W/16){i_data[15:0]}};
      end
      SIZE_WORD: begin
        w_strb = '1;
        w_data = i_data;
      end
      default: begin
        w_strb = '1;
        w_data = i_data;
      end
    endcase
  end

  assign o_accept = r_valid & i_mem_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (i_load) begin
      r_valid <= 1'b1;
    end else if (o_accept) begin
      r_valid <= 1'b0;
    end
  end

  // held until the handshake completes
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_addr <= i_addr;
      r_data <= w_data;
      r_strb <= w_strb;
    end
  end

  assign o_busy      = r_valid;
  assign o_mem_valid = r_valid;
  assign o_mem_addr  = r_addr;
  assign o_mem_data  = r_data;
  assign o_mem_strb  = r_strb;

endmodule

//--- design/stq_top.sv
`timescale 1ns/1ns
`include "stq_consts.svh"

module stq_top (
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_disp_valid,
  output logic               o_disp_ready,
  output stq_pkg::stq_idx_t  o_disp_idx,

  input  logic               i_ex_valid,
  input  stq_pkg::stq_idx_t  i_ex_idx,
  input  stq_pkg::addr_t     i_ex_addr,
  input  stq_pkg::data_t     i_ex_data,
  input  stq_pkg::st_size_t  i_ex_size,

  input  logic               i_commit_valid,
  input  logic               i_flush,

  output logic               o_mem_valid,
  input  logic               i_mem_ready,
  output stq_pkg::addr_t     o_mem_addr,
  output stq_pkg::data_t     o_mem_data,
  output stq_pkg::strb_t     o_mem_strb
);
  import stq_pkg::*;

  stq_state_e w_entry_state [`STQ_ENTRIES];
  addr_t      w_entry_addr  [`STQ_ENTRIES];
  data_t      w_entry_data  [`STQ_ENTRIES];
  st_size_t   w_entry_size  [`STQ_ENTRIES];

  stq_idx_t   w_head_idx;
  logic       w_drain_load;
  logic       w_drain_busy;
  logic       w_drain_accept;

  stq_upd_if u_upd ();

  stq_ctrl u_ctrl (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .o_disp_ready   (o_disp_ready),
    .o_disp_idx     (o_disp_idx),
    .i_ex_valid     (i_ex_valid),
    .i_ex_idx       (i_ex_idx),
    .i_ex_addr      (i_ex_addr),
    .i_ex_data      (i_ex_data),
    .i_ex_size      (i_ex_size),
    .i_commit_valid (i_commit_valid),
    .i_flush        (i_flush),
    .i_entry_state  (w_entry_state),
    .i_drain_busy   (w_drain_busy),
    .i_drain_accept (w_drain_accept),
    .o_head_idx     (w_head_idx),
    .o_drain_load   (w_drain_load),
    .upd            (u_upd.ctrl)
  );

  for (genvar i = 0; i < `STQ_ENTRIES; i++) begin : g_entry
    stq_entry #(.ENTRY_IDX(i)) u_entry (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .upd       (u_upd.entry),
      .o_state   (w_entry_state[i]),
      .o_addr    (w_entry_addr[i]),
      .o_data    (w_entry_data[i]),
      .o_size    (w_entry_size[i])
    );
  end

  // head entry feeds the output register
  stq_drain u_drain (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_load      (w_drain_load),
    .i_addr      (w_entry_addr[w_head_idx]),
    .i_data      (w_entry_data[w_head_idx]),
    .i_size      (w_entry_size[w_head_idx]),
    .o_accept    (w_drain_accept),
    .o_busy      (w_drain_busy),
    .o_mem_valid (o_mem_valid),
    .i_mem_ready (i_mem_ready),
    .o_mem_addr  (o_mem_addr),
    .o_mem_data  (o_mem_data),
    .o_mem_strb  (o_mem_strb)
  );

endmodule

//--- test/stq_chk.sv
`timescale 1ns/1ns
`include "stq_consts.svh"

module stq_chk (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_disp_ready,
  input  stq_pkg::stq_state_e  i_entry_state [`STQ_ENTRIES],
  input  logic                 i_mem_valid,
  input  logic                 i_mem_ready,
  input  stq_pkg::addr_t       i_mem_addr,
  input  stq_pkg::data_t       i_mem_data,
  input  stq_pkg::strb_t       i_mem_strb
);
  import stq_pkg::*;

  stq_oh_t w_busy;
  stq_oh_t w_draining;

  always_comb begin
    for (int i = 0; i < `STQ_ENTRIES; i++) begin
      w_busy[i]     = (i_entry_state[i] != STQ_FREE);
      w_draining[i] = (i_entry_state[i] == STQ_DRAINING);
    end
  end

  // stalled write keeps its payload
  a_hold_payload: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_mem_valid && !i_mem_ready) |=>
      (i_mem_valid && $stable(i_mem_addr) && $stable(i_mem_data) && $stable(i_mem_strb)))
    else $error("memory payload changed while the write was stalled");

  a_full_not_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (&w_busy) |-> !i_disp_ready)
    else $error("dispatch ready while every entry is occupied");

  // only the head may be in the output register
  a_one_draining: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $countones(w_draining) <= 1)
    else $error("more than one entry in the draining state");

endmodule

//--- test/stq_tb.sv
`timescale 1ns/1ns
`include "stq_consts.svh"

module stq_tb;
  import stq_pkg::*;

  localparam int TIMEOUT = 2000;

  logic      i_clk;
  logic      i_reset_n;
  logic      i_disp_valid;
  logic      o_disp_ready;
  stq_idx_t  o_disp_idx;
  logic      i_ex_valid;
  stq_idx_t  i_ex_idx;
  addr_t     i_ex_addr;
  data_t     i_ex_data;
  st_size_t  i_ex_size;
  logic      i_commit_valid;
  logic      i_flush;
  logic      o_mem_valid;
  logic      i_mem_ready;
  addr_t     o_mem_addr;
  data_t     o_mem_data;
  strb_t     o_mem_strb;

  integer    seed;
  integer    rdy_seed;
  int        dir_k;

  // model payload per entry and stores in program order
  addr_t     m_addr [`STQ_ENTRIES];
  data_t     m_data [`STQ_ENTRIES];
  st_size_t  m_size [`STQ_ENTRIES];
  stq_idx_t  m_tail;
  stq_idx_t  m_cmt;
  stq_idx_t  pend_q[$];
  stq_idx_t  batch_q[$];
  addr_t     exp_addr_q[$];
  data_t     exp_data_q[$];
  strb_t     exp_strb_q[$];

  stq_top u_dut (.*);

  bind stq_top stq_chk u_chk (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_ready  (o_disp_ready),
    .i_entry_state (w_entry_state),
    .i_mem_valid   (o_mem_valid),
    .i_mem_ready   (i_mem_ready),
    .i_mem_addr    (o_mem_addr),
    .i_mem_data    (o_mem_data),
    .i_mem_strb    (o_mem_strb)
  );

  initial i_clk = 1'b0;
  always #4 i_clk = ~i_clk;

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_idx(input string name, input stq_idx_t exp, input stq_idx_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  function automatic stq_idx_t next_idx(input stq_idx_t idx);
    return stq_idx_t'((int'(idx) + 1) % `STQ_ENTRIES);
  endfunction

  // each lane covered by the access takes byte (lane mod size) of the store data
  function automatic void expected_write(input addr_t a, input data_t d, input st_size_t s,
                                         output strb_t strb, output data_t lanes);
    int nbytes;
    int off;
    nbytes = (s == SIZE_BYTE) ? 1 : (s == SIZE_HALF) ? 2 : `STQ_DATA_W / 8;
    off    = int'(a[1:0]) & ~(nbytes - 1);
    for (int b = 0; b < `STQ_DATA_W / 8; b++) begin
      strb[b]         = (b >= off) && (b < off + nbytes);
      lanes[8*b +: 8] = d[8*(b % nbytes) +: 8];
    end
  endfunction

  task automatic dispatch_n(input int n);
    int wait_cnt;
    for (int i = 0; i < n; i++) begin
      wait_cnt = 0;
      while (!o_disp_ready) begin
        @(negedge i_clk);
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          $display("Timeout: o_disp_ready stayed low at %0t ns", $time);
          stop_on_error();
        end
      end
      check_idx("o_disp_idx", m_tail, o_disp_idx);
      i_disp_valid = 1'b1;
      pend_q.push_back(m_tail);
      batch_q.push_back(m_tail);
      m_tail = next_idx(m_tail);
      @(negedge i_clk);
      i_disp_valid = 1'b0;
    end
  endtask

  // executes the last dispatched group in random order
  task automatic exec_all(input bit directed);
    int       k;
    stq_idx_t idx;
    addr_t    a;
    st_size_t s;
    while (batch_q.size() > 0) begin
      k   = int'($unsigned($random(seed)) % batch_q.size());
      idx = batch_q[k];
      batch_q.delete(k);
      a = $random(seed);
      if (directed) begin
        // walks every legal size and offset
        s      = (dir_k < 4) ? SIZE_BYTE : (dir_k < 6) ? SIZE_HALF : SIZE_WORD;
        a[1:0] = (dir_k < 4) ? 2'(dir_k) : (dir_k < 6) ? 2'((dir_k - 4) * 2) : 2'd0;
        dir_k++;
      end else begin
        s = st_size_t'($unsigned($random(seed)) % 3);
        if (s == SIZE_HALF) begin
          a[0] = 1'b0;
        end
        if (s == SIZE_WORD) begin
          a[1:0] = 2'b00;
        end
      end
      m_addr[idx] = a;
      m_data[idx] = $random(seed);
      m_size[idx] = s;
      i_ex_valid  = 1'b1;
      i_ex_idx    = idx;
      i_ex_addr   = a;
      i_ex_data   = m_data[idx];
      i_ex_size   = s;
      @(negedge i_clk);
      i_ex_valid = 1'b0;
    end
  endtask

  task automatic commit_n(input int n);
    stq_idx_t idx;
    strb_t    strb;
    data_t    lanes;
    for (int i = 0; i < n; i++) begin
      idx = pend_q.pop_front();
      expected_write(m_addr[idx], m_data[idx], m_size[idx], strb, lanes);
      exp_addr_q.push_back(m_addr[idx]);
      exp_data_q.push_back(lanes);
      exp_strb_q.push_back(strb);
      m_cmt = next_idx(m_cmt);
      i_commit_valid = 1'b1;
      @(negedge i_clk);
      i_commit_valid = 1'b0;
    end
  endtask

  task automatic flush_pending();
    i_flush = 1'b1;
    pend_q.delete();
    batch_q.delete();
    m_tail = m_cmt;
    @(negedge i_clk);
    i_flush = 1'b0;
  endtask

  // memory side with random back-pressure and the compare against the model
  initial begin : mem_responder
    logic  stalled;
    addr_t held_addr;
    data_t held_data;
    strb_t held_strb;
    rdy_seed    = 70;
    stalled     = 1'b0;
    i_mem_ready = 1'b0;
    forever begin
      @(negedge i_clk);
      if (stalled) begin
        check_flag("o_mem_valid", 1'b1, o_mem_valid);
        check_addr("o_mem_addr", held_addr, o_mem_addr);
        check_data("o_mem_data", held_data, o_mem_data);
        check_strb("o_mem_strb", held_strb, o_mem_strb);
      end
      i_mem_ready = ($random(rdy_seed) % 3) != 0;
      // transfer completes at the next rising edge
      if (o_mem_valid && i_mem_ready) begin
        if (exp_addr_q.size() == 0) begin
          $display("Memory write to %h at %0t ns with no committed store left", o_mem_addr,
                   $time);
          stop_on_error();
        end
        check_addr("o_mem_addr", exp_addr_q.pop_front(), o_mem_addr);
        check_data("o_mem_data", exp_data_q.pop_front(), o_mem_data);
        check_strb("o_mem_strb", exp_strb_q.pop_front(), o_mem_strb);
      end
      stalled   = o_mem_valid && !i_mem_ready;
      held_addr = o_mem_addr;
      held_data = o_mem_data;
      held_strb = o_mem_strb;
    end
  end

  initial begin : stimulus
    int wait_cnt;
    int n;
    seed           = 70;
    dir_k          = 0;
    m_tail         = '0;
    m_cmt          = '0;
    i_reset_n      = 1'b0;
    i_disp_valid   = 1'b0;
    i_ex_valid     = 1'b0;
    i_ex_idx       = '0;
    i_ex_addr      = '0;
    i_ex_data      = '0;
    i_ex_size      = '0;
    i_commit_valid = 1'b0;
    i_flush        = 1'b0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    check_flag("o_disp_ready", 1'b1, o_disp_ready);
    check_flag("o_mem_valid", 1'b0, o_mem_valid);

    // fill the queue so indices come back 0 to 3
    dispatch_n(`STQ_ENTRIES);
    check_flag("o_disp_ready", 1'b0, o_disp_ready);
    exec_all(1'b0);
    commit_n(`STQ_ENTRIES);

    // every size at every legal offset
    dispatch_n(4);
    exec_all(1'b1);
    commit_n(4);
    dispatch_n(3);
    exec_all(1'b1);
    commit_n(3);

    // flush with two uncommitted stores behind a committed one
    dispatch_n(3);
    exec_all(1'b0);
    commit_n(1);
    flush_pending();

    repeat (24) begin
      n = 1 + int'($unsigned($random(seed)) % `STQ_ENTRIES);
      dispatch_n(n);
      exec_all(1'b0);
      commit_n(n);
    end

    // last transfer must also finish with nothing left behind it
    wait_cnt = 0;
    while (exp_addr_q.size() > 0 || o_mem_valid) begin
      @(negedge i_clk);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        $display("Timeout: %0d committed stores never reached the memory port",
                 exp_addr_q.size());
        stop_on_error();
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+design
design/stq_pkg.sv
design/stq_upd_if.sv
design/stq_entry.sv
design/stq_ctrl.sv
design/stq_drain.sv
design/stq_top.sv
test/stq_chk.sv
test/stq_tb.sv

//--- Makefile
SIM      := verilator
TOP      := stq_tb
FILELIST := compile.f
FLAGS    := --binary --timing --assert
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(filter-out +%,$(shell cat $(FILELIST))) design/stq_consts.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
